// File: bench/tb_load_buffer.sv
// Load buffer testbench
// Drives loads into the buffer, models the address adder and memory,
// and checks addresses, byte enables, data and retire order

`timescale 1ns/1ps
`include "lb_consts.svh"

module tb_load_buffer;

  localparam int CLK_PERIOD = 8;
  localparam int NUM_TESTS  = 6;

  logic clk_i, rst_ni, flush_i;
  logic issue_valid_i, issue_ready_o, issue_rs1_ready_i;
  lb_pkg::ld_width_t issue_width_i;
  lb_pkg::rob_idx_t  issue_rs1_rob_idx_i, issue_dest_rob_idx_i;
  lb_pkg::xlen_t     issue_rs1_value_i, issue_imm_i;
  logic cdb_valid_i, cdb_valid_o, cdb_ready_i;
  lb_pkg::rob_idx_t  cdb_rob_idx_i, cdb_rob_idx_o;
  lb_pkg::xlen_t     cdb_value_i, cdb_value_o;
  logic adder_valid_o;
  lb_pkg::lb_idx_t   adder_tag_o;
  lb_pkg::xlen_t     adder_base_o, adder_offs_o;
  logic mem_valid_o;
  lb_pkg::lb_idx_t   mem_tag_o;
  lb_pkg::xlen_t     mem_addr_o;
  lb_pkg::be_t       mem_be_o;
  // Driven by the adder and memory models
  logic              adder_ready_i  = 1'b1;
  logic              adder_valid_i  = 1'b0;
  lb_pkg::lb_idx_t   adder_tag_i    = '0;
  lb_pkg::xlen_t     adder_result_i = '0;
  logic              mem_ready_i    = 1'b1;
  logic              mem_valid_i    = 1'b0;
  lb_pkg::lb_idx_t   mem_tag_i      = '0;
  lb_pkg::xlen_t     mem_rdata_i    = '0;

  integer seed = 51687;
  int errors = 0, errors_at_start = 0, tests_run = 0, tests_failed = 0;
  int cycle = 0, tb_tail = 0, pick;
  bit rev_mode = 0, rev_drain = 0;
  lb_pkg::rob_idx_t next_tag = '0;

  // Scoreboard in push order, and per-slot copies of the pushed fields
  lb_pkg::rob_idx_t  sb_tag [$];
  lb_pkg::xlen_t     sb_val [$];
  lb_pkg::ld_width_t slot_width [`LB_DEPTH];
  lb_pkg::xlen_t     slot_base  [`LB_DEPTH];
  lb_pkg::xlen_t     slot_imm   [`LB_DEPTH];
  lb_pkg::rob_idx_t  slot_rs1   [`LB_DEPTH];
  bit                slot_wait  [`LB_DEPTH];

  // Model queues
  lb_pkg::lb_idx_t add_tag [$];
  lb_pkg::xlen_t   add_res [$];
  int              add_due [$];
  lb_pkg::lb_idx_t mq_tag  [$];
  lb_pkg::xlen_t   mq_addr [$];

  load_buffer dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Memory contents as a fixed rule of the aligned address
  function automatic lb_pkg::xlen_t mem_word(lb_pkg::xlen_t a);
    return a * 64'h9E37_79B9_7F4A_7C15;
  endfunction

  function automatic int byte_count(lb_pkg::ld_width_t w);
    case (w)
      lb_pkg::LD_B, lb_pkg::LD_BU: return 1;
      lb_pkg::LD_H, lb_pkg::LD_HU: return 2;
      lb_pkg::LD_W, lb_pkg::LD_WU: return 4;
      default: return 8;
    endcase
  endfunction

  function automatic lb_pkg::be_t expect_be(lb_pkg::ld_width_t w, logic [2:0] off);
    logic [15:0] m;
    m = ((16'd1 << byte_count(w)) - 16'd1) << off;
    return m[7:0];
  endfunction

  // Requested bytes moved down, then extended by the load kind
  function automatic lb_pkg::xlen_t expect_data(lb_pkg::ld_width_t w, lb_pkg::xlen_t addr);
    lb_pkg::xlen_t v;
    int  bits;
    bit  sgn;
    bits = 8 * byte_count(w);
    sgn  = (w == lb_pkg::LD_B) || (w == lb_pkg::LD_H) || (w == lb_pkg::LD_W);
    v    = mem_word({addr[63:3], 3'b000}) >> (8 * addr[2:0]);
    for (int b = bits; b < `LB_XLEN; b++) v[b] = sgn & v[bits-1];
    return v;
  endfunction

  // ------------------------------------------------------------------
  // Protocol checks
  // ------------------------------------------------------------------
  a_cdb_hold: assert property (@(posedge clk_i) disable iff (!rst_ni || flush_i)
    cdb_valid_o && !cdb_ready_i |=> cdb_valid_o && $stable(cdb_rob_idx_o) &&
    $stable(cdb_value_o))
    else begin
      errors++;
      $display("Error at %0t: CDB output changed before acceptance", $time);
    end
  a_adder_hold: assert property (@(posedge clk_i) disable iff (!rst_ni || flush_i)
    adder_valid_o && !adder_ready_i |=> adder_valid_o && $stable(adder_tag_o) &&
    $stable(adder_base_o) && $stable(adder_offs_o))
    else begin
      errors++;
      $display("Error at %0t: adder request dropped or changed", $time);
    end
  a_mem_hold: assert property (@(posedge clk_i) disable iff (!rst_ni || flush_i)
    mem_valid_o && !mem_ready_i |=> mem_valid_o && $stable(mem_tag_o) &&
    $stable(mem_addr_o) && $stable(mem_be_o))
    else begin
      errors++;
      $display("Error at %0t: memory request dropped or changed", $time);
    end
  a_flush_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_i |=> issue_ready_o && !adder_valid_o && !mem_valid_o && !cdb_valid_o)
    else begin
      errors++;
      $display("Error at %0t: buffer not idle after flush", $time);
    end

  // ------------------------------------------------------------------
  // Monitor, adder model and memory model
  // ------------------------------------------------------------------
  always @(posedge clk_i) begin
    cycle++;
    if (rst_ni && flush_i) begin
      sb_tag.delete();
      sb_val.delete();
      add_tag.delete();
      add_res.delete();
      add_due.delete();
      mq_tag.delete();
      mq_addr.delete();
      tb_tail   = 0;
      rev_drain = 0;
      for (int k = 0; k < `LB_DEPTH; k++) slot_wait[k] = 1'b0;
    end else if (rst_ni) begin
      if (adder_valid_o) begin
        assert (!slot_wait[adder_tag_o]) else begin
          errors++;
          $display("Error at %0t: adder request before the base was broadcast", $time);
        end
        assert (adder_base_o == slot_base[adder_tag_o]) else begin
          errors++;
          $display("Fail at %0t: adder_base_o expected %h got %h", $time,
                   slot_base[adder_tag_o], adder_base_o);
        end
        assert (adder_offs_o == slot_imm[adder_tag_o]) else begin
          errors++;
          $display("Fail at %0t: adder_offs_o expected %h got %h", $time,
                   slot_imm[adder_tag_o], adder_offs_o);
        end
        if (adder_ready_i) begin
          add_tag.push_back(adder_tag_o);
          add_res.push_back(adder_base_o + adder_offs_o);
          add_due.push_back(cycle + 1 + ($unsigned($random(seed)) % 3));
        end
      end
      if (mem_valid_o && mem_ready_i) begin
        assert (mem_addr_o == {slot_base[mem_tag_o][63:3] + slot_imm[mem_tag_o][63:3] +
                               61'(({1'b0, slot_base[mem_tag_o][2:0]} +
                                    {1'b0, slot_imm[mem_tag_o][2:0]}) >> 3), 3'b000})
          else begin
            errors++;
            $display("Fail at %0t: mem_addr_o expected %h got %h", $time,
                     (slot_base[mem_tag_o] + slot_imm[mem_tag_o]) & ~64'h7, mem_addr_o);
          end
        assert (mem_be_o == expect_be(slot_width[mem_tag_o],
                                      slot_base[mem_tag_o][2:0] + slot_imm[mem_tag_o][2:0]))
          else begin
            errors++;
            $display("Fail at %0t: mem_be_o expected %h got %h", $time,
                     expect_be(slot_width[mem_tag_o],
                               slot_base[mem_tag_o][2:0] + slot_imm[mem_tag_o][2:0]),
                     mem_be_o);
          end
        mq_tag.push_back(mem_tag_o);
        mq_addr.push_back(mem_addr_o);
      end
      if (cdb_valid_i) begin
        for (int k = 0; k < `LB_DEPTH; k++)
          if (slot_wait[k] && slot_rs1[k] == cdb_rob_idx_i) slot_wait[k] = 1'b0;
      end
      if (cdb_valid_o && cdb_ready_i) begin
        if (sb_tag.size() == 0) begin
          errors++;
          $display("Error at %0t: CDB retired a load that was never pushed", $time);
        end else begin
          assert (cdb_rob_idx_o == sb_tag[0]) else begin
            errors++;
            $display("Fail at %0t: cdb_rob_idx_o expected %h got %h", $time,
                     sb_tag[0], cdb_rob_idx_o);
          end
          assert (cdb_value_o == sb_val[0]) else begin
            errors++;
            $display("Fail at %0t: cdb_value_o expected %h got %h", $time,
                     sb_val[0], cdb_value_o);
          end
          void'(sb_tag.pop_front());
          void'(sb_val.pop_front());
        end
      end
    end
    #1;
    adder_ready_i = ($random(seed) & 3) != 0;
    mem_ready_i   = ($random(seed) & 3) != 0;
    adder_valid_i = 1'b0;
    mem_valid_i   = 1'b0;
    if (add_tag.size() != 0 && add_due[0] <= cycle) begin
      adder_valid_i  = 1'b1;
      adder_tag_i    = add_tag.pop_front();
      adder_result_i = add_res.pop_front();
      void'(add_due.pop_front());
    end
    // Reversed mode collects a full batch, then answers newest first
    pick = -1;
    if (mq_tag.size() == 0) rev_drain = 0;
    else if (rev_mode) begin
      if (mq_tag.size() >= `LB_DEPTH) rev_drain = 1;
      if (rev_drain) pick = mq_tag.size() - 1;
    end else if ($random(seed) & 1) begin
      pick = $unsigned($random(seed)) % mq_tag.size();
    end
    if (pick >= 0) begin
      mem_valid_i = 1'b1;
      mem_tag_i   = mq_tag[pick];
      mem_rdata_i = mem_word(mq_addr[pick]);
      mq_tag.delete(pick);
      mq_addr.delete(pick);
    end
  end

  // ------------------------------------------------------------------
  // Stimulus tasks that start and end 1 ns after a rising edge
  // ------------------------------------------------------------------
  task automatic push_load(input lb_pkg::ld_width_t w, input lb_pkg::xlen_t base,
                           input lb_pkg::xlen_t imm, input bit rs1_rdy,
                           input lb_pkg::rob_idx_t rs1_tag);
    issue_valid_i        = 1'b1;
    issue_width_i        = w;
    issue_rs1_ready_i    = rs1_rdy;
    issue_rs1_rob_idx_i  = rs1_tag;
    // Stale register value when the base is still pending
    issue_rs1_value_i    = rs1_rdy ? base : ~base;
    issue_imm_i          = imm;
    issue_dest_rob_idx_i = next_tag;
    do @(posedge clk_i); while (!issue_ready_o);
    slot_width[tb_tail] = w;
    slot_base[tb_tail]  = base;
    slot_imm[tb_tail]   = imm;
    slot_rs1[tb_tail]   = rs1_tag;
    slot_wait[tb_tail]  = !rs1_rdy;
    sb_tag.push_back(next_tag);
    sb_val.push_back(expect_data(w, base + imm));
    tb_tail  = (tb_tail + 1) % `LB_DEPTH;
    next_tag = next_tag + 1'b1;
    #1;
    issue_valid_i = 1'b0;
  endtask

  task automatic push_random();
    lb_pkg::ld_width_t w;
    w = lb_pkg::ld_width_t'($unsigned($random(seed)) % 7);
    push_load(w, {$random(seed), $random(seed)}, {$random(seed), $random(seed)}, 1'b1, '0);
  endtask

  task automatic wait_drain();
    while (sb_tag.size() != 0) @(negedge clk_i);
    @(posedge clk_i);
    #1;
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (errors != errors_at_start) tests_failed++;
    $display("Test %s %s", name, (errors == errors_at_start) ? "ok" : "with errors");
    errors_at_start = errors;
  endtask

  // ------------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------------
  initial begin
    lb_pkg::xlen_t base, imm;
    rst_ni = 1'b0;
    flush_i = 1'b0;
    issue_valid_i = 1'b0;
    issue_width_i = lb_pkg::LD_D;
    issue_rs1_ready_i = 1'b1;
    issue_rs1_rob_idx_i = '0;
    issue_rs1_value_i = '0;
    issue_imm_i = '0;
    issue_dest_rob_idx_i = '0;
    cdb_valid_i = 1'b0;
    cdb_rob_idx_i = '0;
    cdb_value_i = '0;
    cdb_ready_i = 1'b1;
    repeat (10) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(posedge clk_i);
    #1;

    repeat (12) push_random();
    wait_drain();
    report_test("rs1_ready");

    // Base arrives later on the CDB while a ready load waits behind it
    base = {$random(seed), $random(seed)};
    push_load(lb_pkg::LD_W, base, 64'h40, 1'b0, 5'd17);
    push_random();
    repeat (8) @(posedge clk_i);
    cdb_valid_i   = 1'b1;
    cdb_rob_idx_i = 5'd17;
    cdb_value_i   = base;
    @(posedge clk_i);
    #1;
    cdb_valid_i = 1'b0;
    wait_drain();
    report_test("rs1_pending");

    for (int w = 0; w < 7; w++) begin
      for (int off = 0; off < 8; off++) begin
        base = {$random(seed), $random(seed)} & ~64'h7;
        imm  = ({$random(seed), $random(seed)} & ~64'h7) | off;
        push_load(lb_pkg::ld_width_t'(w), base, imm, 1'b1, '0);
      end
    end
    wait_drain();
    report_test("width_offset");

    rev_mode = 1;
    repeat (`LB_DEPTH) push_random();
    wait_drain();
    rev_mode = 0;
    report_test("reverse_mem");

    cdb_ready_i = 1'b0;
    repeat (`LB_DEPTH) begin
      assert (issue_ready_o) else begin
        errors++;
        $display("Fail at %0t: issue_ready_o expected 1 got %b", $time, issue_ready_o);
      end
      push_random();
    end
    assert (!issue_ready_o) else begin
      errors++;
      $display("Fail at %0t: issue_ready_o expected 0 got %b", $time, issue_ready_o);
    end
    // Head is held for a while once it is ready to retire
    while (!cdb_valid_o) @(posedge clk_i);
    repeat (8) @(posedge clk_i);
    #1;
    assert (cdb_valid_o && !issue_ready_o) else begin
      errors++;
      $display("Error at %0t: full buffer dropped its CDB valid or took a new load", $time);
    end
    cdb_ready_i = 1'b1;
    wait_drain();
    report_test("backpressure");

    repeat (3) push_random();
    flush_i = 1'b1;
    @(posedge clk_i);
    #1;
    flush_i = 1'b0;
    repeat (6) begin
      assert (issue_ready_o && !adder_valid_o && !mem_valid_o && !cdb_valid_o) else begin
        errors++;
        $display("Error at %0t: activity seen after flush", $time);
      end
      @(posedge clk_i);
      #1;
    end
    repeat (`LB_DEPTH) push_random();
    wait_drain();
    report_test("flush");

    $display("Tests run %0d, tests failed %0d, checks failed %0d",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(NUM_TESTS * 2000 * CLK_PERIOD);
    $display("Watchdog expired, the tests did not finish in time");
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// File: hdl/lb_out_sel.sv
// Load buffer output selector
// Routes the slot named by each pointer to its channel, builds the
// byte enables and looks up the slot of a returning memory answer

`timescale 1ns/1ps
`include "lb_consts.svh"

module lb_out_sel (
  input  lb_pkg::lb_idx_t        head_i,
  input  lb_pkg::lb_idx_t        tail_i,
  input  lb_pkg::lb_idx_t        addr_ptr_i,
  input  lb_pkg::lb_idx_t        mem_ptr_i,
  input  lb_pkg::lb_idx_t        mem_tag_i,
  input  logic [`LB_DEPTH-1:0]   empty_i,
  input  logic [`LB_DEPTH-1:0]   addr_req_i,
  input  logic [`LB_DEPTH-1:0]   mem_req_i,
  input  logic [`LB_DEPTH-1:0]   done_i,
  input  lb_pkg::ld_width_t      width_i        [`LB_DEPTH],
  input  lb_pkg::xlen_t          base_i         [`LB_DEPTH],
  input  lb_pkg::xlen_t          offs_addr_i    [`LB_DEPTH],
  input  lb_pkg::rob_idx_t       dest_rob_idx_i [`LB_DEPTH],
  input  lb_pkg::xlen_t          value_i        [`LB_DEPTH],
  output logic                   issue_ready_o,
  output logic                   adder_valid_o,
  output lb_pkg::lb_idx_t        adder_tag_o,
  output lb_pkg::xlen_t          adder_base_o,
  output lb_pkg::xlen_t          adder_offs_o,
  output logic                   mem_valid_o,
  output lb_pkg::xlen_t          mem_addr_o,
  output lb_pkg::be_t            mem_be_o,
  output lb_pkg::lb_idx_t        mem_tag_o,
  output logic                   cdb_valid_o,
  output lb_pkg::rob_idx_t       cdb_rob_idx_o,
  output lb_pkg::xlen_t          cdb_value_o,
  output lb_pkg::ld_width_t      ret_width_o,
  output logic [`LB_OFFS_W-1:0]  ret_offs_o
);

  lb_pkg::xlen_t mem_slot_addr;
  lb_pkg::be_t   be_mask;

  assign issue_ready_o = empty_i[tail_i];

  // Adder channel
  assign adder_valid_o = addr_req_i[addr_ptr_i];
  assign adder_tag_o   = addr_ptr_i;
  assign adder_base_o  = base_i[addr_ptr_i];
  assign adder_offs_o  = offs_addr_i[addr_ptr_i];

  // Memory channel, doubleword aligned
  assign mem_slot_addr = offs_addr_i[mem_ptr_i];
  assign mem_valid_o   = mem_req_i[mem_ptr_i];
  assign mem_tag_o     = mem_ptr_i;
  assign mem_addr_o    = {mem_slot_addr[`LB_XLEN-1:`LB_OFFS_W], {`LB_OFFS_W{1'b0}}};

  always_comb begin
    case (width_i[mem_ptr_i])
      lb_pkg::LD_B, lb_pkg::LD_BU: be_mask = 8'b0000_0001;
      lb_pkg::LD_H, lb_pkg::LD_HU: be_mask = 8'b0000_0011;
      lb_pkg::LD_W, lb_pkg::LD_WU: be_mask = 8'b0000_1111;
      default:                     be_mask = 8'b1111_1111;
    endcase
  end

  // Width mask moved up to the byte offset
  assign mem_be_o = be_mask << mem_slot_addr[`LB_OFFS_W-1:0];

  // CDB channel
  assign cdb_valid_o   = done_i[head_i];
  assign cdb_rob_idx_o = dest_rob_idx_i[head_i];
  assign cdb_value_o   = value_i[head_i];

  // Returning answer
  assign ret_width_o = width_i[mem_tag_i];
  assign ret_offs_o  = offs_addr_i[mem_tag_i][`LB_OFFS_W-1:0];

endmodule

// File: hdl/lb_pkg.sv
// Load buffer types
// Vector typedefs for the meaningful widths, load widths and slot states

`include "lb_consts.svh"

package lb_pkg;

  typedef logic [`LB_XLEN-1:0]          xlen_t;
  typedef logic [`LB_ROB_IDX_W-1:0]     rob_idx_t;
  typedef logic [$clog2(`LB_DEPTH)-1:0] lb_idx_t;
  typedef logic [`LB_BE_W-1:0]          be_t;

  // U variants are zero-extended
  typedef enum logic [2:0] {
    LD_B, LD_BU, LD_H, LD_HU, LD_W, LD_WU, LD_D
  } ld_width_t;

  typedef enum logic [2:0] {
    LB_S_EMPTY,
    LB_S_RS1_WAIT,
    LB_S_ADDR_REQ,
    LB_S_ADDR_WAIT,
    LB_S_MEM_REQ,
    LB_S_MEM_WAIT,
    LB_S_DONE
  } lb_state_t;

endpackage

// File: hdl/lb_ptr_ctl.sv
// Load buffer pointer controller
// Keeps the tail, address, memory and head pointers and turns each
// handshake into a one-hot strobe for the slot its pointer names

`timescale 1ns/1ps
`include "lb_consts.svh"

module lb_ptr_ctl (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  flush_i,
  input  logic                  issue_valid_i,
  input  logic                  issue_ready_i,
  input  logic                  adder_valid_i,
  input  logic                  adder_ready_i,
  input  logic                  mem_valid_i,
  input  logic                  mem_ready_i,
  input  logic                  cdb_valid_i,
  input  logic                  cdb_ready_i,
  output lb_pkg::lb_idx_t       head_o,
  output lb_pkg::lb_idx_t       tail_o,
  output lb_pkg::lb_idx_t       addr_ptr_o,
  output lb_pkg::lb_idx_t       mem_ptr_o,
  output logic [`LB_DEPTH-1:0]  push_o,
  output logic [`LB_DEPTH-1:0]  addr_sent_o,
  output logic [`LB_DEPTH-1:0]  mem_sent_o,
  output logic [`LB_DEPTH-1:0]  pop_o
);

  // Pointer order: tail, address, memory, head
  logic [3:0]      fire;
  lb_pkg::lb_idx_t ptr_q [4];

  assign fire[0] = issue_valid_i & issue_ready_i;
  assign fire[1] = adder_valid_i & adder_ready_i;
  assign fire[2] = mem_valid_i & mem_ready_i;
  assign fire[3] = cdb_valid_i & cdb_ready_i;

  // Wrapping counters
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int k = 0; k < 4; k++) ptr_q[k] <= '0;
    end else if (flush_i) begin
      for (int k = 0; k < 4; k++) ptr_q[k] <= '0;
    end else begin
      for (int k = 0; k < 4; k++) begin
        if (fire[k]) begin
          if (ptr_q[k] == lb_pkg::lb_idx_t'(`LB_DEPTH - 1)) ptr_q[k] <= '0;
          else ptr_q[k] <= ptr_q[k] + 1'b1;
        end
      end
    end
  end

  assign tail_o     = ptr_q[0];
  assign addr_ptr_o = ptr_q[1];
  assign mem_ptr_o  = ptr_q[2];
  assign head_o     = ptr_q[3];

  // Per-slot strobes
  always_comb begin
    for (int i = 0; i < `LB_DEPTH; i++) begin
      push_o[i]      = fire[0] && (ptr_q[0] == lb_pkg::lb_idx_t'(i));
      addr_sent_o[i] = fire[1] && (ptr_q[1] == lb_pkg::lb_idx_t'(i));
      mem_sent_o[i]  = fire[2] && (ptr_q[2] == lb_pkg::lb_idx_t'(i));
      pop_o[i]       = fire[3] && (ptr_q[3] == lb_pkg::lb_idx_t'(i));
    end
  end

endmodule

// File: hdl/lb_slot.sv
// Load buffer slot
// Holds one load and steps it through base wait, address computation,
// memory access and retirement

`timescale 1ns/1ps

module lb_slot #(
  parameter int unsigned SLOT_IDX = 0
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              flush_i,
  input  logic              push_i,
  input  logic              addr_sent_i,
  input  logic              mem_sent_i,
  input  logic              pop_i,
  // Issue fields
  input  lb_pkg::ld_width_t issue_width_i,
  input  logic              issue_rs1_ready_i,
  input  lb_pkg::rob_idx_t  issue_rs1_rob_idx_i,
  input  lb_pkg::xlen_t     issue_rs1_value_i,
  input  lb_pkg::xlen_t     issue_imm_i,
  input  lb_pkg::rob_idx_t  issue_dest_rob_idx_i,
  // CDB broadcast
  input  logic              cdb_valid_i,
  input  lb_pkg::rob_idx_t  cdb_rob_idx_i,
  input  lb_pkg::xlen_t     cdb_value_i,
  // Answers
  input  logic              adder_valid_i,
  input  lb_pkg::lb_idx_t   adder_tag_i,
  input  lb_pkg::xlen_t     adder_result_i,
  input  logic              mem_valid_i,
  input  lb_pkg::lb_idx_t   mem_tag_i,
  input  lb_pkg::xlen_t     load_data_i,
  // Status and fields
  output logic              empty_o,
  output logic              addr_req_o,
  output logic              mem_req_o,
  output logic              done_o,
  output lb_pkg::ld_width_t width_o,
  output lb_pkg::xlen_t     base_o,
  output lb_pkg::xlen_t     offs_addr_o,
  output lb_pkg::rob_idx_t  dest_rob_idx_o,
  output lb_pkg::xlen_t     value_o
);

  lb_pkg::lb_state_t state_q, state_d;

  lb_pkg::ld_width_t width_q;
  lb_pkg::rob_idx_t  rs1_rob_idx_q;
  lb_pkg::rob_idx_t  dest_rob_idx_q;
  lb_pkg::xlen_t     base_q;
  lb_pkg::xlen_t     offs_addr_q;
  lb_pkg::xlen_t     value_q;

  logic rs1_fwd, rs1_take, addr_take, mem_take;

  // Base broadcast on the same edge as the push
  assign rs1_fwd   = cdb_valid_i && (cdb_rob_idx_i == issue_rs1_rob_idx_i);
  assign rs1_take  = (state_q == lb_pkg::LB_S_RS1_WAIT) && cdb_valid_i &&
                     (cdb_rob_idx_i == rs1_rob_idx_q);
  // Answers may come while the request is still pending
  assign addr_take = adder_valid_i && (adder_tag_i == lb_pkg::lb_idx_t'(SLOT_IDX)) &&
                     (state_q == lb_pkg::LB_S_ADDR_REQ || state_q == lb_pkg::LB_S_ADDR_WAIT);
  assign mem_take  = mem_valid_i && (mem_tag_i == lb_pkg::lb_idx_t'(SLOT_IDX)) &&
                     (state_q == lb_pkg::LB_S_MEM_REQ || state_q == lb_pkg::LB_S_MEM_WAIT);

  // ------------------------------------------------------------------
  // State machine
  // ------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      lb_pkg::LB_S_EMPTY: begin
        if (push_i) begin
          if (issue_rs1_ready_i || rs1_fwd) state_d = lb_pkg::LB_S_ADDR_REQ;
          else state_d = lb_pkg::LB_S_RS1_WAIT;
        end
      end
      lb_pkg::LB_S_RS1_WAIT: if (rs1_take) state_d = lb_pkg::LB_S_ADDR_REQ;
      lb_pkg::LB_S_ADDR_REQ: begin
        if (addr_take) state_d = lb_pkg::LB_S_MEM_REQ;
        else if (addr_sent_i) state_d = lb_pkg::LB_S_ADDR_WAIT;
      end
      lb_pkg::LB_S_ADDR_WAIT: if (addr_take) state_d = lb_pkg::LB_S_MEM_REQ;
      lb_pkg::LB_S_MEM_REQ: begin
        if (mem_take) state_d = lb_pkg::LB_S_DONE;
        else if (mem_sent_i) state_d = lb_pkg::LB_S_MEM_WAIT;
      end
      lb_pkg::LB_S_MEM_WAIT: if (mem_take) state_d = lb_pkg::LB_S_DONE;
      lb_pkg::LB_S_DONE: if (pop_i) state_d = lb_pkg::LB_S_EMPTY;
      default: state_d = lb_pkg::LB_S_EMPTY;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) state_q <= lb_pkg::LB_S_EMPTY;
    else if (flush_i) state_q <= lb_pkg::LB_S_EMPTY;
    else state_q <= state_d;
  end

  // ------------------------------------------------------------------
  // Load fields
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      width_q        <= issue_width_i;
      rs1_rob_idx_q  <= issue_rs1_rob_idx_i;
      dest_rob_idx_q <= issue_dest_rob_idx_i;
      base_q         <= (!issue_rs1_ready_i && rs1_fwd) ? cdb_value_i : issue_rs1_value_i;
      offs_addr_q    <= issue_imm_i;
    end else begin
      if (rs1_take) base_q <= cdb_value_i;
      // Offset is replaced by the computed address
      if (addr_take) offs_addr_q <= adder_result_i;
      if (mem_take) value_q <= load_data_i;
    end
  end

  assign empty_o        = state_q == lb_pkg::LB_S_EMPTY;
  assign addr_req_o     = state_q == lb_pkg::LB_S_ADDR_REQ;
  assign mem_req_o      = state_q == lb_pkg::LB_S_MEM_REQ;
  assign done_o         = state_q == lb_pkg::LB_S_DONE;
  assign width_o        = width_q;
  assign base_o         = base_q;
  assign offs_addr_o    = offs_addr_q;
  assign dest_rob_idx_o = dest_rob_idx_q;
  assign value_o        = value_q;

endmodule

// File: hdl/load_buffer.sv
// Out-of-order load buffer
// Slots are filled in program order, compute addresses and read memory
// out of order, and retire on the CDB in program order

`timescale 1ns/1ps
`include "lb_consts.svh"

module load_buffer (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              flush_i,
  // Issue stage
  input  logic              issue_valid_i,
  output logic              issue_ready_o,
  input  lb_pkg::ld_width_t issue_width_i,
  input  logic              issue_rs1_ready_i,
  input  lb_pkg::rob_idx_t  issue_rs1_rob_idx_i,
  input  lb_pkg::xlen_t     issue_rs1_value_i,
  input  lb_pkg::xlen_t     issue_imm_i,
  input  lb_pkg::rob_idx_t  issue_dest_rob_idx_i,
  // CDB
  input  logic              cdb_valid_i,
  input  lb_pkg::rob_idx_t  cdb_rob_idx_i,
  input  lb_pkg::xlen_t     cdb_value_i,
  output logic              cdb_valid_o,
  input  logic              cdb_ready_i,
  output lb_pkg::rob_idx_t  cdb_rob_idx_o,
  output lb_pkg::xlen_t     cdb_value_o,
  // Address adder
  output logic              adder_valid_o,
  input  logic              adder_ready_i,
  output lb_pkg::lb_idx_t   adder_tag_o,
  output lb_pkg::xlen_t     adder_base_o,
  output lb_pkg::xlen_t     adder_offs_o,
  input  logic              adder_valid_i,
  input  lb_pkg::lb_idx_t   adder_tag_i,
  input  lb_pkg::xlen_t     adder_result_i,
  // Memory
  output logic              mem_valid_o,
  input  logic              mem_ready_i,
  output lb_pkg::xlen_t     mem_addr_o,
  output lb_pkg::be_t       mem_be_o,
  output lb_pkg::lb_idx_t   mem_tag_o,
  input  logic              mem_valid_i,
  input  lb_pkg::lb_idx_t   mem_tag_i,
  input  lb_pkg::xlen_t     mem_rdata_i
);

  lb_pkg::lb_idx_t head, tail, addr_ptr, mem_ptr;

  logic [`LB_DEPTH-1:0] push, addr_sent, mem_sent, pop;
  logic [`LB_DEPTH-1:0] slot_empty, slot_addr_req, slot_mem_req, slot_done;

  lb_pkg::ld_width_t slot_width     [`LB_DEPTH];
  lb_pkg::xlen_t     slot_base      [`LB_DEPTH];
  lb_pkg::xlen_t     slot_offs_addr [`LB_DEPTH];
  lb_pkg::rob_idx_t  slot_dest      [`LB_DEPTH];
  lb_pkg::xlen_t     slot_value     [`LB_DEPTH];

  // Memory answer path
  lb_pkg::ld_width_t       ret_width;
  logic [`LB_OFFS_W-1:0]   ret_offs;
  lb_pkg::xlen_t           load_data;

  lb_ptr_ctl u_ptr_ctl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .issue_valid_i (issue_valid_i),
    .issue_ready_i (issue_ready_o),
    .adder_valid_i (adder_valid_o),
    .adder_ready_i (adder_ready_i),
    .mem_valid_i   (mem_valid_o),
    .mem_ready_i   (mem_ready_i),
    .cdb_valid_i   (cdb_valid_o),
    .cdb_ready_i   (cdb_ready_i),
    .head_o        (head),
    .tail_o        (tail),
    .addr_ptr_o    (addr_ptr),
    .mem_ptr_o     (mem_ptr),
    .push_o        (push),
    .addr_sent_o   (addr_sent),
    .mem_sent_o    (mem_sent),
    .pop_o         (pop)
  );

  // ------------------------------------------------------------------
  // Buffer slots
  // ------------------------------------------------------------------
  for (genvar i = 0; i < `LB_DEPTH; i++) begin : gen_slot
    lb_slot #(
      .SLOT_IDX(i)
    ) u_slot (
      .clk_i                (clk_i),
      .rst_ni               (rst_ni),
      .flush_i              (flush_i),
      .push_i               (push[i]),
      .addr_sent_i          (addr_sent[i]),
      .mem_sent_i           (mem_sent[i]),
      .pop_i                (pop[i]),
      .issue_width_i        (issue_width_i),
      .issue_rs1_ready_i    (issue_rs1_ready_i),
      .issue_rs1_rob_idx_i  (issue_rs1_rob_idx_i),
      .issue_rs1_value_i    (issue_rs1_value_i),
      .issue_imm_i          (issue_imm_i),
      .issue_dest_rob_idx_i (issue_dest_rob_idx_i),
      .cdb_valid_i          (cdb_valid_i),
      .cdb_rob_idx_i        (cdb_rob_idx_i),
      .cdb_value_i          (cdb_value_i),
      .adder_valid_i        (adder_valid_i),
      .adder_tag_i          (adder_tag_i),
      .adder_result_i       (adder_result_i),
      .mem_valid_i          (mem_valid_i),
      .mem_tag_i            (mem_tag_i),
      .load_data_i          (load_data),
      .empty_o              (slot_empty[i]),
      .addr_req_o           (slot_addr_req[i]),
      .mem_req_o            (slot_mem_req[i]),
      .done_o               (slot_done[i]),
      .width_o              (slot_width[i]),
      .base_o               (slot_base[i]),
      .offs_addr_o          (slot_offs_addr[i]),
      .dest_rob_idx_o       (slot_dest[i]),
      .value_o              (slot_value[i])
    );
  end

  lb_out_sel u_out_sel (
    .head_i         (head),
    .tail_i         (tail),
    .addr_ptr_i     (addr_ptr),
    .mem_ptr_i      (mem_ptr),
    .mem_tag_i      (mem_tag_i),
    .empty_i        (slot_empty),
    .addr_req_i     (slot_addr_req),
    .mem_req_i      (slot_mem_req),
    .done_i         (slot_done),
    .width_i        (slot_width),
    .base_i         (slot_base),
    .offs_addr_i    (slot_offs_addr),
    .dest_rob_idx_i (slot_dest),
    .value_i        (slot_value),
    .issue_ready_o  (issue_ready_o),
    .adder_valid_o  (adder_valid_o),
    .adder_tag_o    (adder_tag_o),
    .adder_base_o   (adder_base_o),
    .adder_offs_o   (adder_offs_o),
    .mem_valid_o    (mem_valid_o),
    .mem_addr_o     (mem_addr_o),
    .mem_be_o       (mem_be_o),
    .mem_tag_o      (mem_tag_o),
    .cdb_valid_o    (cdb_valid_o),
    .cdb_rob_idx_o  (cdb_rob_idx_o),
    .cdb_value_o    (cdb_value_o),
    .ret_width_o    (ret_width),
    .ret_offs_o     (ret_offs)
  );

  load_extract u_extract (
    .width_i (ret_width),
    .offs_i  (ret_offs),
    .rdata_i (mem_rdata_i),
    .data_o  (load_data)
  );

endmodule

// File: hdl/load_extract.sv
// Load data extractor
// Picks the requested bytes out of a returned doubleword and
// sign- or zero-extends them to the full width

`timescale 1ns/1ps
`include "lb_consts.svh"

module load_extract (
  input  lb_pkg::ld_width_t     width_i,
  input  logic [`LB_OFFS_W-1:0] offs_i,
  input  lb_pkg::xlen_t         rdata_i,
  output lb_pkg::xlen_t         data_o
);

  lb_pkg::xlen_t shifted;

  // Byte offset to bit shift
  assign shifted = rdata_i >> {offs_i, 3'b000};

  always_comb begin
    case (width_i)
      lb_pkg::LD_B:  data_o = {{(`LB_XLEN - 8){shifted[7]}}, shifted[7:0]};
      lb_pkg::LD_BU: data_o = {{(`LB_XLEN - 8){1'b0}}, shifted[7:0]};
      lb_pkg::LD_H:  data_o = {{(`LB_XLEN - 16){shifted[15]}}, shifted[15:0]};
      lb_pkg::LD_HU: data_o = {{(`LB_XLEN - 16){1'b0}}, shifted[15:0]};
      lb_pkg::LD_W:  data_o = {{(`LB_XLEN - 32){shifted[31]}}, shifted[31:0]};
      lb_pkg::LD_WU: data_o = {{(`LB_XLEN - 32){1'b0}}, shifted[31:0]};
      default:       data_o = shifted;
    endcase
  end

endmodule

// File: include/lb_consts.svh
// Load buffer constants
// Widths and sizes shared by the package, the RTL and the testbench

`ifndef LB_CONSTS_SVH
`define LB_CONSTS_SVH

// Data and address width
`define LB_XLEN 64

// Number of buffer slots
`define LB_DEPTH 4

// Reorder buffer tag width
`define LB_ROB_IDX_W 5

// Byte offset inside a doubleword, and its byte enables
`define LB_OFFS_W 3
`define LB_BE_W 8

`endif

// File: src.f
+incdir+include
hdl/lb_pkg.sv
hdl/lb_ptr_ctl.sv
hdl/lb_slot.sv
hdl/lb_out_sel.sv
hdl/load_extract.sv
hdl/load_buffer.sv
bench/tb_load_buffer.sv
